// File: src/scalerPkg.sv
package scalerPkg;

    localparam int PixelWidth = 8;
    localparam int FracBits = 8;                        // Blend fraction
    localparam int CoeffWidth = FracBits + 1;           // Q1.8
    localparam int ScaleIntBits = 4;
    localparam int ScaleFracBits = 14;
    localparam int ScaleWidth = ScaleIntBits + ScaleFracBits;
    localparam int ResWidth = 11;                       // Sizes are given minus 1
    localparam int PosWidth = ResWidth + ScaleFracBits;

    typedef logic [PixelWidth-1:0] pixelT;
    typedef logic [CoeffWidth-1:0] coeffT;
    typedef logic [ScaleWidth-1:0] scaleT;              // Q4.14 step per output pixel
    typedef logic [ResWidth-1:0] resT;
    typedef logic [PosWidth-1:0] posT;                  // Input coordinate, integer then fraction

    // Q1.8 constants
    localparam coeffT CoeffOne = coeffT'(1 << FracBits);
    localparam coeffT CoeffHalf = coeffT'(1 << (FracBits - 1));

    // Write side FSM
    typedef enum logic [1:0] {WsIdle, WsRead, WsDone} writeStateT;

    // Read side FSM
    typedef enum logic [1:0] {RsWait, RsLine, RsDone} readStateT;

endpackage

// File: src/lineWriter.sv
`timescale 1ns/1ps

module lineWriter import scalerPkg::*; #(
    parameter int BufferDepth = 4
) (
    input  logic clk,
    input  logic start,
    input  pixelT inPixel,
    input  logic inValid,
    input  resT inputXRes,
    input  resT inputYRes,
    input  scaleT yScale,
    input  logic [$clog2(BufferDepth+1)-1:0] fillCount,
    output logic inReady,
    output logic writeEnable,
    output resT writeAddress,
    output pixelT writePixel,
    output logic advanceWrite,
    output logic twoLinesReady,
    output logic allWritten
);
    localparam int ProdWidth = ResWidth + ScaleWidth;

    writeStateT state;
    resT colCount;                      // Column of the next pixel
    resT rowCount;                      // Input row being received
    resT lineK;                         // Output line of the tracked top neighbor
    resT neededLine;                    // floor(lineK * yScale)
    logic [ProdWidth-1:0] neededProd;
    logic keepLine;                     // Current row goes into the ring
    logic accept;
    logic lastCol;

    assign neededProd = ProdWidth'(lineK) * ProdWidth'(yScale);
    assign neededLine = neededProd[ScaleFracBits +: ResWidth];

    assign inReady = (state == WsRead) && (fillCount < BufferDepth);   // Stall when ring is full
    assign accept = inValid && inReady;
    assign lastCol = colCount == inputXRes;
    assign writeEnable = accept && keepLine;   // Unused rows are taken but dropped
    assign writeAddress = colCount;
    assign writePixel = inPixel;
    assign advanceWrite = writeEnable && lastCol;
    assign allWritten = state == WsDone;

    // Walk the output lines until the needed line catches up with the current row,
    // so the decision for the following row is ready at the end of this one
    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            lineK <= '0;
        end else if (neededLine < rowCount) begin
            lineK <= lineK + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            state <= WsIdle;
            colCount <= '0;
            rowCount <= '0;
            keepLine <= 1'b1;           // Row 0 always needed
            twoLinesReady <= 1'b0;
        end else begin
            case (state)
                WsIdle: state <= WsRead;
                WsRead: begin
                    if (accept && lastCol) begin
                        colCount <= '0;
                        rowCount <= rowCount + 1'b1;
                        // Next row kept if it is the needed line or the one below it
                        keepLine <= neededLine <= resT'(rowCount + 1'b1);
                        if (rowCount == resT'(1)) begin
                            twoLinesReady <= 1'b1;
                        end
                        if (rowCount == inputYRes) begin
                            state <= WsDone;
                        end
                    end else if (accept) begin
                        colCount <= colCount + 1'b1;
                    end
                end
                default: ;                  // Frame finished, wait for start
            endcase
        end
    end

endmodule

// File: src/lineRing.sv
`timescale 1ns/1ps

module lineRing import scalerPkg::*; #(
    parameter int BufferDepth = 4
) (
    input  logic clk,
    input  logic start,
    input  logic writeEnable,
    input  resT writeAddress,
    input  pixelT writePixel,
    input  logic advanceWrite,
    input  logic advanceRead1,
    input  logic advanceRead2,
    input  resT readAddress,
    output logic [$clog2(BufferDepth+1)-1:0] fillCount,
    output pixelT pix00,                // Top left
    output pixelT pix01,                // Top right
    output pixelT pix10,                // Bottom left
    output pixelT pix11                 // Bottom right
);
    localparam int PtrWidth = $clog2(BufferDepth);
    localparam int CountWidth = $clog2(BufferDepth + 1);

    typedef logic [PtrWidth-1:0] ptrT;

    pixelT lineMem [BufferDepth][1 << ResWidth];
    ptrT writePtr;                      // Line being filled
    ptrT readPtr;                       // Top line of the blend window
    ptrT readPtrNext;                   // Bottom line
    resT readAddressNext;
    logic [CountWidth-1:0] readDec;

    // Ring step with wrap, depth need not be a power of two
    function automatic ptrT wrapInc(ptrT p);
        return (p == ptrT'(BufferDepth - 1)) ? '0 : ptrT'(p + 1'b1);
    endfunction

    assign readPtrNext = wrapInc(readPtr);
    assign readAddressNext = resT'(readAddress + 1'b1);
    assign readDec = advanceRead2 ? CountWidth'(2) : CountWidth'(advanceRead1);

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (advanceWrite) begin
                writePtr <= wrapInc(writePtr);
            end
            if (advanceRead2) begin
                readPtr <= wrapInc(readPtrNext);    // Skip two lines
            end else if (advanceRead1) begin
                readPtr <= readPtrNext;
            end
            fillCount <= fillCount + CountWidth'(advanceWrite) - readDec;   // Complete lines held
        end
    end

    // Line RAMs, one write port and a registered four-pixel read
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            lineMem[writePtr][writeAddress] <= writePixel;
        end
        pix00 <= lineMem[readPtr][readAddress];
        pix01 <= lineMem[readPtr][readAddressNext];
        pix10 <= lineMem[readPtrNext][readAddress];
        pix11 <= lineMem[readPtrNext][readAddressNext];
    end

endmodule

// File: src/readSequencer.sv
`timescale 1ns/1ps

module readSequencer import scalerPkg::*; #(
    parameter int BufferDepth = 4
) (
    input  logic clk,
    input  logic start,
    input  logic outReady,
    input  resT outputXRes,
    input  resT outputYRes,
    input  resT inputXRes,
    input  scaleT xScale,
    input  scaleT yScale,
    input  logic [$clog2(BufferDepth+1)-1:0] fillCount,
    input  logic twoLinesReady,
    input  logic allWritten,
    output logic advanceRead1,
    output logic advanceRead2,
    output resT readAddress,
    output logic clampRight,
    output posT xPos,
    output posT yPos,
    output logic issue
);
    readStateT state;
    resT outColumn;
    resT outLine;
    posT yNext;                         // Position of the following output line
    resT yInt;
    resT yNextInt;
    logic lineSwitch;                   // Gap while the ring pointer moves
    logic dataOk;
    logic lastColumn;

    assign yInt = yPos[ScaleFracBits +: ResWidth];
    assign yNextInt = yNext[ScaleFracBits +: ResWidth];
    assign readAddress = xPos[ScaleFracBits +: ResWidth];   // Left neighbor column
    assign clampRight = readAddress == inputXRes;           // No pixel right of the last column
    assign dataOk = (fillCount >= 2) || allWritten;         // Both window lines present
    assign lastColumn = outColumn == outputXRes;
    assign issue = (state == RsLine) && outReady && !lineSwitch && dataOk;

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            state <= RsWait;
            outColumn <= '0;
            outLine <= '0;
            xPos <= '0;
            yPos <= '0;
            yNext <= '0;
            lineSwitch <= 1'b0;
            advanceRead1 <= 1'b0;
            advanceRead2 <= 1'b0;
        end else begin
            advanceRead1 <= 1'b0;       // Single-cycle pulses
            advanceRead2 <= 1'b0;
            lineSwitch <= 1'b0;
            case (state)
                RsWait: begin
                    yNext <= posT'(yScale);     // Line 1 sits at 1*yScale
                    if (twoLinesReady) begin
                        state <= RsLine;
                    end
                end
                RsLine: begin
                    if (issue && lastColumn) begin
                        outColumn <= '0;
                        xPos <= '0;
                        outLine <= outLine + 1'b1;
                        yPos <= yNext;
                        yNext <= yNext + posT'(yScale);
                        lineSwitch <= 1'b1;
                        // Move the window by the step between top neighbor rows
                        if (yNextInt == resT'(yInt + 1'b1)) begin
                            advanceRead1 <= 1'b1;
                        end else if (yNextInt > resT'(yInt + 1'b1)) begin
                            advanceRead2 <= 1'b1;   // Lines between were never written
                        end
                        if (outLine == outputYRes) begin
                            state <= RsDone;
                        end
                    end else if (issue) begin
                        outColumn <= outColumn + 1'b1;
                        xPos <= xPos + posT'(xScale);
                    end
                end
                default: ;                  // All pixels issued
            endcase
        end
    end

endmodule

// File: src/coeffGen.sv
`timescale 1ns/1ps

module coeffGen import scalerPkg::*; (
    input  logic clk,
    input  logic start,
    input  posT xPos,
    input  posT yPos,
    input  logic nearestNeighbor,
    output coeffT coeff00,
    output coeffT coeff01,
    output coeffT coeff10,
    output coeffT coeff11
);
    coeffT xBlend;                      // Weight of the right column
    coeffT yBlend;                      // Weight of the bottom line
    coeffT xInv;
    coeffT yInv;
    logic xHigh;
    logic yHigh;

    // Q1.8 product, rounded with half minus one then scaled back
    function automatic coeffT weight(coeffT a, coeffT b);
        logic [2*CoeffWidth-1:0] prod;
        prod = (2*CoeffWidth)'(a) * (2*CoeffWidth)'(b) + (2*CoeffWidth)'(CoeffHalf - 1'b1);
        return coeffT'(prod >> FracBits);
    endfunction

    assign xInv = CoeffOne - xBlend;
    assign yInv = CoeffOne - yBlend;
    assign xHigh = xBlend >= CoeffHalf;     // Closer to the right neighbor
    assign yHigh = yBlend >= CoeffHalf;     // Closer to the bottom neighbor

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            xBlend <= '0;
            yBlend <= '0;
            coeff00 <= '0;
            coeff01 <= '0;
            coeff10 <= '0;
            coeff11 <= '0;
        end else begin
            // Top fraction bits of each position
            xBlend <= {1'b0, xPos[ScaleFracBits-1 -: FracBits]};
            yBlend <= {1'b0, yPos[ScaleFracBits-1 -: FracBits]};
            if (nearestNeighbor) begin
                coeff00 <= (!xHigh && !yHigh) ? CoeffOne : '0;
                coeff01 <= (xHigh && !yHigh) ? CoeffOne : '0;
                coeff10 <= (!xHigh && yHigh) ? CoeffOne : '0;
                coeff11 <= (xHigh && yHigh) ? CoeffOne : '0;
            end else begin
                coeff00 <= weight(xInv, yInv);
                coeff01 <= weight(xBlend, yInv);
                coeff10 <= weight(xInv, yBlend);
                coeff11 <= weight(xBlend, yBlend);
            end
        end
    end

endmodule

// File: src/blendDatapath.sv
`timescale 1ns/1ps

module blendDatapath import scalerPkg::*; (
    input  logic clk,
    input  logic start,
    input  pixelT pix00,
    input  pixelT pix01,
    input  pixelT pix10,
    input  pixelT pix11,
    input  coeffT coeff00,
    input  coeffT coeff01,
    input  coeffT coeff10,
    input  coeffT coeff11,
    input  logic clampRight,
    input  logic issue,
    output pixelT outPixel,
    output logic outValid
);
    localparam int ProdWidth = PixelWidth + CoeffWidth;
    localparam int SumWidth = ProdWidth + 2;

    pixelT pixReg00, pixReg01, pixReg10, pixReg11;
    logic [ProdWidth-1:0] product00, product01, product10, product11;
    logic [SumWidth-1:0] sum;
    logic clampDly;                     // Lines up with the ring read data
    logic [2:0] issueDly;

    assign sum = SumWidth'(product00) + SumWidth'(product01)
               + SumWidth'(product10) + SumWidth'(product11);

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            clampDly <= 1'b0;
            issueDly <= '0;
            outValid <= 1'b0;
        end else begin
            clampDly <= clampRight;
            issueDly <= {issueDly[1:0], issue};    // Ring, neighbor, product stages
            outValid <= issueDly[2];               // Sum stage
        end
    end

    always_ff @(posedge clk) begin
        pixReg00 <= pix00;
        pixReg01 <= clampDly ? pix00 : pix01;   // Right edge repeats the last column
        pixReg10 <= pix10;
        pixReg11 <= clampDly ? pix10 : pix11;
        product00 <= ProdWidth'(pixReg00) * ProdWidth'(coeff00);
        product01 <= ProdWidth'(pixReg01) * ProdWidth'(coeff01);
        product10 <= ProdWidth'(pixReg10) * ProdWidth'(coeff10);
        product11 <= ProdWidth'(pixReg11) * ProdWidth'(coeff11);
        outPixel <= pixelT'(sum >> FracBits);   // Drop fraction, keep low 8 bits
    end

endmodule

// File: src/streamScaler.sv
`timescale 1ns/1ps

module streamScaler #(
    parameter int BufferDepth = 4           // Line RAMs in the ring, 3 or more
) (
    input  logic clk,
    input  logic start,                     // Async reset, begins a new frame
    input  logic [7:0] inPixel,
    input  logic inValid,
    output logic inReady,
    output logic [7:0] outPixel,
    output logic outValid,                  // 4 cycles after an issued request
    input  logic outReady,
    input  logic [10:0] inputXRes,          // Sizes minus 1
    input  logic [10:0] inputYRes,
    input  logic [10:0] outputXRes,
    input  logic [10:0] outputYRes,
    input  logic [17:0] xScale,             // Q4.14 input step per output pixel
    input  logic [17:0] yScale,
    input  logic nearestNeighbor
);
    localparam int CountWidth = $clog2(BufferDepth + 1);

    logic writeEnable, advanceWrite, twoLinesReady, allWritten;
    logic [10:0] writeAddress, readAddress;
    logic [7:0] writePixel;
    logic [7:0] pix00, pix01, pix10, pix11;
    logic [CountWidth-1:0] fillCount;
    logic advanceRead1, advanceRead2, clampRight, issue;
    logic [24:0] xPos, yPos;
    logic [8:0] coeff00, coeff01, coeff10, coeff11;

    // Write side, line store, read control, weights, blend
    lineWriter #(.BufferDepth(BufferDepth)) writer (.*);
    lineRing #(.BufferDepth(BufferDepth)) ring (.*);
    readSequencer #(.BufferDepth(BufferDepth)) sequencer (.*);
    coeffGen coeffs (.*);
    blendDatapath blend (.*);

endmodule

// File: verification/streamScaler_chk.sv
`timescale 1ns/1ps

module streamScaler_chk (
    input logic clk,
    input logic start,
    input logic [7:0] inPixel,
    input logic inValid,
    input logic inReady,
    input logic outValid,
    input logic outReady
);
    int failures = 0;                       // Summed by the testbench after each test

    // Each output answers a request from exactly 4 cycles before
    validAfterRequest: assert property (@(posedge clk) disable iff (start)
        outValid |-> $past(outReady, 4))
        else begin
            $error("outValid without outReady 4 cycles earlier");
            failures++;
        end

    // Stalled input holds its pixel
    stalledPixelStable: assert property (@(posedge clk) disable iff (start)
        (inValid && !inReady) |=> $stable(inPixel))
        else begin
            $error("inPixel changed while stalled");
            failures++;
        end

    // Both sides quiet right after reset
    quietAfterReset: assert property (@(posedge clk)
        $fell(start) |-> (!inReady && !outValid))
        else begin
            $error("inReady or outValid high after start fell");
            failures++;
        end

endmodule

bind streamScaler streamScaler_chk chk (
    .clk(clk),
    .start(start),
    .inPixel(inPixel),
    .inValid(inValid),
    .inReady(inReady),
    .outValid(outValid),
    .outReady(outReady)
);

// File: verification/scalerModel.svh
`ifndef SCALER_MODEL_SVH
`define SCALER_MODEL_SVH

// Input picture, each pixel a function of column, row and frame number
function automatic int framePixel(int x, int y, int frame);
    return (x * 29 + y * 53 + frame * 71 + ((x ^ y) << 3)) & 255;
endfunction

// Q1.8 weight product, rounded with half minus one
function automatic int blendWeight(int a, int b);
    return ((a * b + 127) >> 8) & 511;
endfunction

// Output pixel (c, l) sits at input position c*xs, l*ys, both Q4.14
function automatic int expectedPixel(int c, int l, int lastCol, int xs, int ys,
                                     bit nearest, int frame);
    int xp, yp, x0, y0, x1;
    int xf, yf, sum;
    int w00, w01, w10, w11;
    xp = c * xs;
    yp = l * ys;
    x0 = xp >> 14;
    y0 = yp >> 14;
    x1 = (x0 == lastCol) ? x0 : x0 + 1;     // Right edge repeats the last column
    xf = (xp >> 6) & 255;                   // Top 8 fraction bits
    yf = (yp >> 6) & 255;
    if (nearest) begin
        // Neighbor on the same side of half in both axes
        w00 = (xf < 128 && yf < 128) ? 256 : 0;
        w01 = (xf >= 128 && yf < 128) ? 256 : 0;
        w10 = (xf < 128 && yf >= 128) ? 256 : 0;
        w11 = (xf >= 128 && yf >= 128) ? 256 : 0;
    end else begin
        w00 = blendWeight(256 - xf, 256 - yf);
        w01 = blendWeight(xf, 256 - yf);
        w10 = blendWeight(256 - xf, yf);
        w11 = blendWeight(xf, yf);
    end
    sum = framePixel(x0, y0, frame) * w00 + framePixel(x1, y0, frame) * w01
        + framePixel(x0, y0 + 1, frame) * w10 + framePixel(x1, y0 + 1, frame) * w11;
    return (sum >> 8) & 255;                // Fraction dropped, low 8 bits kept
endfunction

// A row is stored if it is a needed top row or the row just below one
function automatic bit rowKept(int r, int ys);
    int k;
    int top;
    k = 0;
    top = 0;
    while (top <= r) begin
        if (top == r || top + 1 == r) begin
            return 1'b1;
        end
        k++;
        top = (k * ys) >> 14;
    end
    return 1'b0;
endfunction

function automatic int keptLines(int lastRow, int ys);
    int n;
    int r;
    n = 0;
    for (r = 0; r <= lastRow; r++) begin
        n += int'(rowKept(r, ys));
    end
    return n;
endfunction

`endif

// File: verification/tbStreamScaler.sv
`timescale 1ns/1ps

module tbStreamScaler;
    `include "scalerModel.svh"

    localparam int WaitLimit = 2000;        // Cycles for any single wait
    localparam int Unity = 16384;           // Scale 1.0 in Q4.14

    logic clk;
    logic start;
    logic [7:0] inPixel;
    logic inValid;
    logic inReady;
    logic [7:0] outPixel;
    logic outValid;
    logic outReady;
    logic [10:0] inputXRes;
    logic [10:0] inputYRes;
    logic [10:0] outputXRes;
    logic [10:0] outputYRes;
    logic [17:0] xScale;
    logic [17:0] yScale;
    logic nearestNeighbor;

    logic [31:0] gapRng;                    // Input gap stream
    logic [31:0] readyRng;                  // Output request stream
    int errors;
    int testsRun;
    int testsFailed;
    int received;                           // Pixels checked in the current frame
    int keptSeen;                           // Lines the writer stored this frame
    int frameId;
    bit abortFrame;                         // Stops all frame processes

    streamScaler #(.BufferDepth(4)) streamScaler_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // advanceWrite is stable at the falling edge before its transfer
    always @(negedge clk) begin
        if (start) begin
            keptSeen = 0;
        end else if (streamScaler_inst.advanceWrite) begin
            keptSeen++;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic applyReset(int inW, int inH, int outW, int outH, int xs, int ys, bit nearest);
        @(posedge clk);
        #1;
        start = 1'b1;
        inValid = 1'b0;
        outReady = 1'b0;
        inputXRes = 11'(inW - 1);               // Sizes minus 1
        inputYRes = 11'(inH - 1);
        outputXRes = 11'(outW - 1);
        outputYRes = 11'(outH - 1);
        xScale = 18'(xs);
        yScale = 18'(ys);
        nearestNeighbor = nearest;
        repeat (4) @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic feedFrame(bit gaps);
        int x;
        int y;
        int waited;
        for (y = 0; y <= int'(inputYRes) && !abortFrame; y++) begin
            for (x = 0; x <= int'(inputXRes) && !abortFrame; x++) begin
                if (gaps) begin
                    gapRng = xorshift32(gapRng);
                    if (gapRng[2:0] < 3'd3) begin      // Idle for 1 to 4 cycles
                        inValid = 1'b0;
                        repeat (int'(gapRng[4:3]) + 1) @(posedge clk);
                        #1;
                    end
                end
                inPixel = 8'(framePixel(x, y, frameId));
                inValid = 1'b1;
                waited = 0;
                @(negedge clk);
                while (!inReady && !abortFrame && waited < WaitLimit) begin
                    @(negedge clk);
                    waited++;
                end
                if (waited >= WaitLimit) begin
                    $display("Input stalled: inReady low for %0d cycles at pixel %0d,%0d",
                             WaitLimit, x, y);
                    errors++;
                    abortFrame = 1'b1;
                end
                @(posedge clk);                 // Transfer edge
                #1;
            end
        end
        inValid = 1'b0;
    endtask

    task automatic requestOutput(bit randomReady, int total);
        int waited;
        waited = 0;
        while (received < total && !abortFrame && waited < 16 * WaitLimit) begin
            readyRng = xorshift32(readyRng);
            outReady = randomReady ? readyRng[0] : 1'b1;
            @(posedge clk);
            #1;
            waited++;
        end
        if (waited >= 16 * WaitLimit) begin
            $display("Output requests not all answered within %0d cycles", 16 * WaitLimit);
            errors++;
            abortFrame = 1'b1;
        end
        outReady = 1'b0;
    endtask

    task automatic checkOutput(int total, int limit);
        int c;
        int l;
        int expected;
        int waited;
        int extra;
        c = 0;
        l = 0;
        extra = 0;
        while (received < limit && !abortFrame) begin
            waited = 0;
            @(negedge clk);
            while (!outValid && !abortFrame && waited < WaitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!outValid && !abortFrame) begin
                $display("No output pixel within %0d cycles, %0d of %0d received",
                         WaitLimit, received, total);
                errors++;
                abortFrame = 1'b1;
            end else if (outValid) begin
                expected = expectedPixel(c, l, int'(inputXRes), int'(xScale), int'(yScale),
                                         nearestNeighbor, frameId);
                assert (outPixel == 8'(expected)) else begin
                    $display("Fail at %0t: outPixel at (%0d,%0d) expected %0d, got %0d",
                             $time, c, l, expected, outPixel);
                    errors++;
                end
                received++;
                c++;
                if (c > int'(outputXRes)) begin
                    c = 0;
                    l++;
                end
            end
        end
        if (limit < total) begin
            abortFrame = 1'b1;                  // Planned stop before the restart
        end else if (!abortFrame) begin
            repeat (20) begin                   // Nothing may follow the last pixel
                @(negedge clk);
                extra += int'(outValid);
            end
            assert (received + extra == total) else begin
                $display("Fail at %0t: outValid count expected %0d, got %0d",
                         $time, total, received + extra);
                errors++;
            end
        end
    endtask

    task automatic runTest(string name, int inW, int inH, int outW, int outH,
                           int xs, int ys, bit nearest, bit gaps, int stopAfter);
        int errorsBefore;
        int chkBefore;
        int total;
        errorsBefore = errors;
        chkBefore = streamScaler_inst.chk.failures;
        frameId++;
        applyReset(inW, inH, outW, outH, xs, ys, nearest);
        total = outW * outH;
        received = 0;
        abortFrame = 1'b0;
        fork
            feedFrame(gaps);
            requestOutput(gaps, total);
            checkOutput(total, (stopAfter > 0) ? stopAfter : total);
        join
        if (stopAfter == 0) begin
            assert (keptSeen == keptLines(inH - 1, ys)) else begin
                $display("Fail at %0t: advanceWrite count expected %0d, got %0d",
                         $time, keptLines(inH - 1, ys), keptSeen);
                errors++;
            end
        end
        errors += streamScaler_inst.chk.failures - chkBefore;
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
        end
        $display("Test %0d %s: %0d pixels checked, %0d errors",
                 testsRun, name, received, errors - errorsBefore);
    endtask

    initial begin
        start = 1'b1;
        inPixel = '0;
        inValid = 1'b0;
        outReady = 1'b0;
        inputXRes = '0;
        inputYRes = '0;
        outputXRes = '0;
        outputYRes = '0;
        xScale = '0;
        yScale = '0;
        nearestNeighbor = 1'b0;
        gapRng = 32'h731f;
        readyRng = ~32'h731f;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        received = 0;
        frameId = 0;
        abortFrame = 1'b0;

        runTest("identity", 8, 6, 8, 6, Unity, Unity, 1'b0, 1'b0, 0);
        // Last output column lands on the last input column, so it is clamped
        runTest("2x bilinear", 6, 5, 12, 8, Unity / 2, Unity / 2, 1'b0, 1'b0, 0);
        runTest("2x nearest", 6, 5, 12, 8, Unity / 2, Unity / 2, 1'b1, 1'b0, 0);
        runTest("2.5x downscale", 8, 10, 4, 4, 40960, 40960, 1'b0, 1'b0, 0);
        runTest("2x random handshakes", 6, 5, 12, 8, Unity / 2, Unity / 2, 1'b0, 1'b1, 0);
        runTest("restart mid-frame", 6, 5, 12, 8, Unity / 2, Unity / 2, 1'b0, 1'b1, 20);
        runTest("frame after restart", 6, 5, 12, 8, Unity / 2, Unity / 2, 1'b0, 1'b0, 0);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verification
src/scalerPkg.sv
src/lineWriter.sv
src/lineRing.sv
src/readSequencer.sv
src/coeffGen.sv
src/blendDatapath.sv
src/streamScaler.sv
verification/streamScaler_chk.sv
verification/tbStreamScaler.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbStreamScaler
BUILD_DIR ?= obj_dir
FILE_LIST ?= tb.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Result: PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard verification/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
